// File: hdl/xform_defines.svh
// Block edge is fixed at 4 because the butterflies in fdct4x4 are hand-unrolled for that size
`ifndef XFORM_DEFINES_SVH
`define XFORM_DEFINES_SVH

// Block geometry
`define XF_BLK_DIM 4

// Pixel and coefficient widths
`define XF_PIX_W   8
`define XF_COEF_W  12

// Nonzero count, 0 to 16
`define XF_NZ_W    5

// Quantiser shift, 0 to 7
`define XF_SHIFT_W 3

`endif

// File: hdl/xform_cmd_pkg.sv
// Opcode codes are fixed by the host side and the two reserved codes are always rejected
package xform_cmd_pkg;

    // --------------------
    // Host opcodes
    // --------------------
    typedef enum logic [1:0] {
        OP_FDCT   = 2'd0, // Raw coefficients
        OP_FDCT_Q = 2'd1, // Coefficients after rounding shift
        OP_RSV2   = 2'd2, // Reserved
        OP_RSV3   = 2'd3  // Reserved
    } op_e;

    // --------------------
    // Handshake states
    // --------------------
    // BUSY waits for ack, DONE waits for req to drop
    typedef enum logic [1:0] {
        IDLE = 2'd0,
        BUSY = 2'd1,
        DONE = 2'd2
    } hs_state_e;

endpackage

// File: hdl/xform_coef_pkg.sv
// Constants follow the VP8 forward transform and only hold for 8-bit pixels and 4x4 blocks
`include "xform_defines.svh"

package xform_coef_pkg;

    // Output coefficient and row-pass intermediate
    typedef logic signed [`XF_COEF_W-1:0] coef_t;
    typedef logic signed [13:0]           tmp_t;

    // --------------------
    // Rotation multipliers
    // --------------------
    localparam int K_A = 2217; // sqrt(2)*cos(3pi/8) scaled
    localparam int K_B = 5352; // sqrt(2)*sin(3pi/8) scaled

    // --------------------
    // Rounding terms
    // --------------------
    // Row pass, before >>> 9
    localparam int RND_R1 = 1812;
    localparam int RND_R3 = 937;

    // Column pass, before >>> 16
    localparam int RND_C1 = 12000;
    localparam int RND_C3 = 51000;

endpackage

// File: hdl/xform_cmd_decode.sv
// Operands and opcode must stay stable while req_i is high and only one request is open at a time
`timescale 1ns/10ps
`include "xform_defines.svh"

module xform_cmd_decode (
    input  logic                                             clk,
    input  logic                                             rst_n,
    input  logic                                             req_i,
    input  xform_cmd_pkg::op_e                               op_i,
    input  logic [`XF_SHIFT_W-1:0]                           shift_i,
    input  logic [`XF_BLK_DIM*`XF_BLK_DIM*`XF_PIX_W-1:0]     src_i,
    input  logic [`XF_BLK_DIM*`XF_BLK_DIM*`XF_PIX_W-1:0]     ref_i,
    input  logic                                             ack_i,
    output logic                                             start_o,
    output logic                                             reject_o,
    output logic                                             req_low_o,
    output xform_cmd_pkg::op_e                               op_o,
    output logic [`XF_SHIFT_W-1:0]                           shift_o,
    output logic [`XF_BLK_DIM*`XF_BLK_DIM*`XF_PIX_W-1:0]     src_o,
    output logic [`XF_BLK_DIM*`XF_BLK_DIM*`XF_PIX_W-1:0]     ref_o
);

    xform_cmd_pkg::hs_state_e state_q;
    logic                     accept;
    logic                     op_ok;

    // New request seen while idle
    assign accept = (state_q == xform_cmd_pkg::IDLE) && req_i;
    assign op_ok  = (op_i == xform_cmd_pkg::OP_FDCT) || (op_i == xform_cmd_pkg::OP_FDCT_Q);

    // Host has dropped req after ack so result releases ack this edge
    assign req_low_o = (state_q != xform_cmd_pkg::IDLE) && ack_i && !req_i;

    // --------------------
    // Handshake FSM
    // --------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q  <= xform_cmd_pkg::IDLE;
            start_o  <= 1'b0;
            reject_o <= 1'b0;
        end else begin
            start_o  <= 1'b0; // Single-cycle pulses
            reject_o <= 1'b0;
            case (state_q)
                xform_cmd_pkg::IDLE: begin
                    if (accept) begin
                        state_q  <= xform_cmd_pkg::BUSY;
                        start_o  <= op_ok;
                        reject_o <= !op_ok;
                    end
                end
                xform_cmd_pkg::BUSY: begin
                    if (req_low_o) begin
                        state_q <= xform_cmd_pkg::IDLE; // req already gone with ack
                    end else if (ack_i) begin
                        state_q <= xform_cmd_pkg::DONE;
                    end
                end
                xform_cmd_pkg::DONE: begin
                    if (req_low_o) begin
                        state_q <= xform_cmd_pkg::IDLE;
                    end
                end
                default: state_q <= xform_cmd_pkg::IDLE;
            endcase
        end
    end

    // Operands held until the next accepted request
    always_ff @(posedge clk) begin
        if (accept) begin
            op_o    <= op_i;
            shift_o <= shift_i;
            src_o   <= src_i;
            ref_o   <= ref_i;
        end
    end

    // --------------------
    // Checks
    // --------------------
    // Result drops ack on the same edge that decode returns to IDLE
    a_idle_ack_low: assert property (@(posedge clk) disable iff (!rst_n)
        (state_q == xform_cmd_pkg::IDLE) |-> !ack_i);

    a_start_one_cycle: assert property (@(posedge clk) disable iff (!rst_n)
        start_o |=> !start_o);

endmodule

// File: hdl/fdct4x4.sv
// Fixed 4x4 forward DCT with results two cycles after start_i and data registers that start as X
`timescale 1ns/10ps
`include "xform_defines.svh"

module fdct4x4 (
    input  logic                                             clk,
    input  logic                                             rst_n,
    input  logic                                             start_i,
    input  logic [`XF_BLK_DIM*`XF_BLK_DIM*`XF_PIX_W-1:0]     src_i,
    input  logic [`XF_BLK_DIM*`XF_BLK_DIM*`XF_PIX_W-1:0]     ref_i,
    output logic [`XF_BLK_DIM*`XF_BLK_DIM*`XF_COEF_W-1:0]    coef_o,
    output logic                                             valid_o
);

    localparam int DIM    = `XF_BLK_DIM;
    localparam int NUM_EL = `XF_BLK_DIM * `XF_BLK_DIM;

    logic signed [`XF_PIX_W:0] res   [NUM_EL]; // src minus ref in 9 bits
    xform_coef_pkg::tmp_t      row_d [NUM_EL];
    xform_coef_pkg::tmp_t      row_q [NUM_EL];
    xform_coef_pkg::coef_t     col_d [NUM_EL];
    xform_coef_pkg::coef_t     col_q [NUM_EL];
    logic                      valid_d1;

    // --------------------
    // Residual and output packing
    // --------------------
    for (genvar k = 0; k < NUM_EL; k++) begin : g_el
        assign res[k] = $signed({1'b0, src_i[k*`XF_PIX_W +: `XF_PIX_W]})
                      - $signed({1'b0, ref_i[k*`XF_PIX_W +: `XF_PIX_W]});
        assign coef_o[k*`XF_COEF_W +: `XF_COEF_W] = col_q[k];
    end

    // --------------------
    // Row pass
    // --------------------
    for (genvar r = 0; r < DIM; r++) begin : g_row
        logic signed [`XF_PIX_W+1:0] s0, s1, s2, s3;
        logic signed [31:0]          p_a2, p_b3, p_a3, p_b2;

        assign s0 = res[DIM*r+0] + res[DIM*r+3];
        assign s1 = res[DIM*r+1] + res[DIM*r+2];
        assign s2 = res[DIM*r+1] - res[DIM*r+2];
        assign s3 = res[DIM*r+0] - res[DIM*r+3];

        assign p_a2 = s2 * xform_coef_pkg::K_A;
        assign p_b3 = s3 * xform_coef_pkg::K_B;
        assign p_a3 = s3 * xform_coef_pkg::K_A;
        assign p_b2 = s2 * xform_coef_pkg::K_B;

        assign row_d[DIM*r+0] = xform_coef_pkg::tmp_t'((s0 + s1) * 8);
        assign row_d[DIM*r+1] =
            xform_coef_pkg::tmp_t'((p_a2 + p_b3 + xform_coef_pkg::RND_R1) >>> 9);
        assign row_d[DIM*r+2] = xform_coef_pkg::tmp_t'((s0 - s1) * 8);
        assign row_d[DIM*r+3] =
            xform_coef_pkg::tmp_t'((p_a3 - p_b2 + xform_coef_pkg::RND_R3) >>> 9);
    end

    // --------------------
    // Column pass
    // --------------------
    // Column c reads rows 0..3 at c, c+4, c+8, c+12
    for (genvar c = 0; c < DIM; c++) begin : g_col
        logic signed [14:0] u0, u1, u2, u3;
        logic signed [31:0] q_a2, q_b3, q_a3, q_b2;
        logic signed [31:0] r1, r3;

        assign u0 = row_q[c] + row_q[c+3*DIM];
        assign u1 = row_q[c+DIM] + row_q[c+2*DIM];
        assign u2 = row_q[c+DIM] - row_q[c+2*DIM];
        assign u3 = row_q[c] - row_q[c+3*DIM];

        // Own product wires for the second pass
        assign q_a2 = u2 * xform_coef_pkg::K_A;
        assign q_b3 = u3 * xform_coef_pkg::K_B;
        assign q_a3 = u3 * xform_coef_pkg::K_A;
        assign q_b2 = u2 * xform_coef_pkg::K_B;

        assign r1 = (q_a2 + q_b3 + xform_coef_pkg::RND_C1) >>> 16;
        assign r3 = (q_a3 - q_b2 + xform_coef_pkg::RND_C3) >>> 16;

        assign col_d[c]       = xform_coef_pkg::coef_t'((u0 + u1 + 7) >>> 4);
        assign col_d[c+DIM]   = xform_coef_pkg::coef_t'(r1 + ((u3 != '0) ? 32'sd1 : 32'sd0));
        assign col_d[c+2*DIM] = xform_coef_pkg::coef_t'((u0 - u1 + 7) >>> 4);
        assign col_d[c+3*DIM] = xform_coef_pkg::coef_t'(r3);
    end

    // Pipeline data loaded only when a block moves forward
    always_ff @(posedge clk) begin
        if (start_i) begin
            row_q <= row_d;
        end
        if (valid_d1) begin
            col_q <= col_d;
        end
    end

    // Two-deep valid pipe
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_d1 <= 1'b0;
            valid_o  <= 1'b0;
        end else begin
            valid_d1 <= start_i;
            valid_o  <= valid_d1;
        end
    end

    a_valid_lat: assert property (@(posedge clk) disable iff (!rst_n)
        start_i |-> ##2 valid_o);

    // Marked output must come from captured operands
    a_valid_data: assert property (@(posedge clk) disable iff (!rst_n)
        valid_o |-> !$isunknown(coef_o));

endmodule

// File: hdl/coef_quant.sv
// Shift quantiser stands in for real tables, outputs hold while ack_o is high
`timescale 1ns/10ps
`include "xform_defines.svh"

module coef_quant (
    input  logic                                             clk,
    input  logic                                             rst_n,
    input  logic [`XF_BLK_DIM*`XF_BLK_DIM*`XF_COEF_W-1:0]    coef_i,
    input  logic                                             valid_i,
    input  logic                                             reject_i,
    input  logic                                             req_low_i,
    input  xform_cmd_pkg::op_e                               op_i,
    input  logic [`XF_SHIFT_W-1:0]                           shift_i,
    output logic [`XF_BLK_DIM*`XF_BLK_DIM*`XF_COEF_W-1:0]    coef_o,
    output logic [`XF_NZ_W-1:0]                              nz_count_o,
    output logic                                             ack_o,
    output logic                                             err_o
);

    localparam int NUM_EL = `XF_BLK_DIM * `XF_BLK_DIM;
    localparam int W      = `XF_COEF_W;
    localparam int NZ_W   = `XF_NZ_W;

    logic [NUM_EL*W-1:0] level;
    logic [NUM_EL-1:0]   nz_flag;
    logic [NZ_W-1:0]     nz_next;
    logic [W:0]          half;

    // 2^(shift-1), zero for shift 0
    assign half = ({{W{1'b0}}, 1'b1} << shift_i) >> 1;

    // --------------------
    // Per-coefficient level
    // --------------------
    for (genvar k = 0; k < NUM_EL; k++) begin : g_lvl
        xform_coef_pkg::coef_t c;
        logic signed [W:0]     c_ext;
        logic [W:0]            mag;
        logic [W:0]            rnd;
        logic [W:0]            q_s;

        assign c     = coef_i[k*W +: W];
        assign c_ext = c;                        // Sign extend, -2048 needs 13 bits
        assign mag   = c_ext[W] ? -c_ext : c_ext;
        assign rnd   = (mag + half) >> shift_i;
        assign q_s   = c_ext[W] ? -rnd : rnd;    // Sign restored

        assign level[k*W +: W] = (op_i == xform_cmd_pkg::OP_FDCT_Q) ? q_s[W-1:0] : c;
        assign nz_flag[k]      = (level[k*W +: W] != '0);
    end

    // Nonzero count for the skip decision
    always_comb begin
        nz_next = '0;
        for (int k = 0; k < NUM_EL; k++) begin
            if (nz_flag[k]) begin
                nz_next = nz_next + NZ_W'(1);
            end
        end
    end

    // --------------------
    // Result registers and ack
    // --------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            coef_o     <= '0;
            nz_count_o <= '0;
            ack_o      <= 1'b0;
            err_o      <= 1'b0;
        end else if (req_low_i) begin
            ack_o <= 1'b0;      // Data stays, only ack drops
        end else if (valid_i) begin
            coef_o     <= level;
            nz_count_o <= nz_next;
            ack_o      <= 1'b1;
            err_o      <= 1'b0;
        end else if (reject_i) begin
            coef_o     <= '0;
            nz_count_o <= '0;
            ack_o      <= 1'b1;
            err_o      <= 1'b1;
        end
    end

    // Decode must not start a new block while the previous one is acknowledged
    a_no_new_during_ack: assert property (@(posedge clk) disable iff (!rst_n)
        (valid_i || reject_i) |-> !ack_o);

endmodule

// File: hdl/xform_top.sv
// One block in flight, ack_o rises three cycles after req_i is sampled for a valid opcode
`timescale 1ns/10ps
`include "xform_defines.svh"

module xform_top (
    input  logic                                             clk,
    input  logic                                             rst_n,
    input  logic                                             req_i,
    input  xform_cmd_pkg::op_e                               op_i,
    input  logic [`XF_SHIFT_W-1:0]                           shift_i,
    input  logic [`XF_BLK_DIM*`XF_BLK_DIM*`XF_PIX_W-1:0]     src_i,
    input  logic [`XF_BLK_DIM*`XF_BLK_DIM*`XF_PIX_W-1:0]     ref_i,
    output logic                                             ack_o,
    output logic                                             err_o,
    output logic [`XF_BLK_DIM*`XF_BLK_DIM*`XF_COEF_W-1:0]    coef_o,
    output logic [`XF_NZ_W-1:0]                              nz_count_o
);

    // Decode outputs
    logic                                            start;
    logic                                            reject;
    logic                                            req_low;
    xform_cmd_pkg::op_e                              op_lat;
    logic [`XF_SHIFT_W-1:0]                          shift_lat;
    logic [`XF_BLK_DIM*`XF_BLK_DIM*`XF_PIX_W-1:0]    src_lat;
    logic [`XF_BLK_DIM*`XF_BLK_DIM*`XF_PIX_W-1:0]    ref_lat;

    // Transform outputs
    logic [`XF_BLK_DIM*`XF_BLK_DIM*`XF_COEF_W-1:0]   dct_coef;
    logic                                            dct_valid;

    xform_cmd_decode u_decode (
        .clk       (clk),
        .rst_n     (rst_n),
        .req_i     (req_i),
        .op_i      (op_i),
        .shift_i   (shift_i),
        .src_i     (src_i),
        .ref_i     (ref_i),
        .ack_i     (ack_o),
        .start_o   (start),
        .reject_o  (reject),
        .req_low_o (req_low),
        .op_o      (op_lat),
        .shift_o   (shift_lat),
        .src_o     (src_lat),
        .ref_o     (ref_lat)
    );

    fdct4x4 u_fdct (
        .clk     (clk),
        .rst_n   (rst_n),
        .start_i (start),
        .src_i   (src_lat),
        .ref_i   (ref_lat),
        .coef_o  (dct_coef),
        .valid_o (dct_valid)
    );

    coef_quant u_quant (
        .clk        (clk),
        .rst_n      (rst_n),
        .coef_i     (dct_coef),
        .valid_i    (dct_valid),
        .reject_i   (reject),
        .req_low_i  (req_low),
        .op_i       (op_lat),
        .shift_i    (shift_lat),
        .coef_o     (coef_o),
        .nz_count_o (nz_count_o),
        .ack_o      (ack_o),
        .err_o      (err_o)
    );

endmodule

// File: test/tb_xform_top.sv
// Drives one request at a time and stops at the first mismatch and shift_i is ignored under OP_FDCT
`timescale 1ns/10ps
`include "xform_defines.svh"

module tb_xform_top;

    localparam int NUM_EL   = `XF_BLK_DIM * `XF_BLK_DIM;
    localparam int PIX_BITS = NUM_EL * `XF_PIX_W;
    localparam int CW       = `XF_COEF_W;
    localparam int CBITS    = NUM_EL * CW;
    localparam int TIMEOUT  = 300 * 12 + 8; // Requests times cycles per request plus reset

    logic                   clk = 1'b0;
    logic                   rst_n;
    logic                   req_i;
    xform_cmd_pkg::op_e     op_i;
    logic [`XF_SHIFT_W-1:0] shift_i;
    logic [PIX_BITS-1:0]    src_i;
    logic [PIX_BITS-1:0]    ref_i;
    logic                   ack_o;
    logic                   err_o;
    logic [CBITS-1:0]       coef_o;
    logic [`XF_NZ_W-1:0]    nz_count_o;

    logic [31:0]            rng_state = 32'h07c3e35d;
    logic [31:0]            rnd;
    int                     cycle_count = 0;
    logic [PIX_BITS-1:0]    blk_src;
    logic [PIX_BITS-1:0]    blk_ref;
    logic [CBITS-1:0]       got_coef;   // coef_o of the last request
    logic [CBITS-1:0]       raw_coef;
    logic [`XF_SHIFT_W-1:0] sh;

    xform_top dut0 (
        .clk        (clk),
        .rst_n      (rst_n),
        .req_i      (req_i),
        .op_i       (op_i),
        .shift_i    (shift_i),
        .src_i      (src_i),
        .ref_i      (ref_i),
        .ack_o      (ack_o),
        .err_o      (err_o),
        .coef_o     (coef_o),
        .nz_count_o (nz_count_o)
    );

    always #10 clk = ~clk;

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT) begin
            abort_run($sformatf("Timeout after %0d cycles, the run did not finish", TIMEOUT));
        end
    end

    // --------------------
    // Helpers
    // --------------------
    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Checks failed");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_equal(input string name, input logic [CBITS-1:0] got,
                               input logic [CBITS-1:0] exp);
        if (got !== exp) begin
            abort_run($sformatf("Fail %s: got 0x%0h, expected 0x%0h", name, got, exp));
        end
    endtask

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic logic [31:0] rand_next();
        rng_state = xorshift32(rng_state);
        return rng_state;
    endfunction

    // First four blocks are the corner cases and the rest mostly random
    function automatic int pick_kind(input int i);
        logic [31:0] r;
        r = rand_next();
        if (i < 4) begin
            return i + 1;
        end
        return (r[2:0] == 3'd0) ? 1 : (r[2:0] == 3'd1) ? 4 : 0;
    endfunction

    task automatic make_block(input int kind);
        logic [31:0] r;
        for (int k = 0; k < NUM_EL; k++) begin
            r = rand_next();
            case (kind)
                1: r[15:8] = r[7:0];                     // src equal to ref
                2: r[15:0] = 16'h00ff;                   // 255 against 0
                3: r[15:0] = 16'hff00;                   // 0 against 255
                4: r[15:8] = r[7:0] ^ {6'b0, r[17:16]};  // Small residual
                default: ;
            endcase
            blk_src[k*`XF_PIX_W +: `XF_PIX_W] = r[7:0];
            blk_ref[k*`XF_PIX_W +: `XF_PIX_W] = r[15:8];
        end
    endtask

    // --------------------
    // Reference model
    // --------------------
    task automatic expected_result(input logic [PIX_BITS-1:0] src_px,
                                   input logic [PIX_BITS-1:0] ref_px,
                                   input xform_cmd_pkg::op_e op,
                                   input logic [`XF_SHIFT_W-1:0] shv,
                                   output logic [CBITS-1:0] exp_coef,
                                   output logic [`XF_NZ_W-1:0] exp_nz);
        int d[NUM_EL];
        int t[NUM_EL];
        int o[NUM_EL];
        int s0, s1, s2, s3;
        int u0, u1, u2, u3;
        int half, mag, q, lvl, nz;
        exp_coef = '0;
        exp_nz   = '0;
        if (op == xform_cmd_pkg::OP_RSV2 || op == xform_cmd_pkg::OP_RSV3) begin
            return;
        end
        for (int k = 0; k < NUM_EL; k++) begin
            d[k] = int'(src_px[k*`XF_PIX_W +: `XF_PIX_W]) - int'(ref_px[k*`XF_PIX_W +: `XF_PIX_W]);
        end
        for (int r = 0; r < 4; r++) begin
            s0 = d[4*r] + d[4*r+3];
            s1 = d[4*r+1] + d[4*r+2];
            s2 = d[4*r+1] - d[4*r+2];
            s3 = d[4*r] - d[4*r+3];
            t[4*r]   = (s0 + s1) * 8;
            t[4*r+1] = (s2 * xform_coef_pkg::K_A + s3 * xform_coef_pkg::K_B
                        + xform_coef_pkg::RND_R1) >>> 9;
            t[4*r+2] = (s0 - s1) * 8;
            t[4*r+3] = (s3 * xform_coef_pkg::K_A - s2 * xform_coef_pkg::K_B
                        + xform_coef_pkg::RND_R3) >>> 9;
        end
        for (int c = 0; c < 4; c++) begin
            u0 = t[c] + t[c+12];
            u1 = t[c+4] + t[c+8];
            u2 = t[c+4] - t[c+8];
            u3 = t[c] - t[c+12];
            o[c]    = (u0 + u1 + 7) >>> 4;
            o[c+4]  = ((u2 * xform_coef_pkg::K_A + u3 * xform_coef_pkg::K_B
                        + xform_coef_pkg::RND_C1) >>> 16) + ((u3 != 0) ? 1 : 0);
            o[c+8]  = (u0 - u1 + 7) >>> 4;
            o[c+12] = (u3 * xform_coef_pkg::K_A - u2 * xform_coef_pkg::K_B
                       + xform_coef_pkg::RND_C3) >>> 16;
        end
        half = (shv == '0) ? 0 : (1 << (int'(shv) - 1));
        nz   = 0;
        for (int k = 0; k < NUM_EL; k++) begin
            lvl = o[k];
            if (op == xform_cmd_pkg::OP_FDCT_Q) begin
                mag = (o[k] < 0) ? -o[k] : o[k];
                q   = (mag + half) >> int'(shv);
                lvl = (o[k] < 0) ? -q : q;
            end
            exp_coef[k*CW +: CW] = lvl[CW-1:0];
            nz = nz + ((lvl != 0) ? 1 : 0);
        end
        exp_nz = nz[`XF_NZ_W-1:0];
    endtask

    task automatic check_outputs(input logic [CBITS-1:0] exp_coef,
                                 input logic [`XF_NZ_W-1:0] exp_nz, input logic exp_err);
        check_equal("ack_o", CBITS'(ack_o), CBITS'(1'b1));
        check_equal("err_o", CBITS'(err_o), CBITS'(exp_err));
        check_equal("nz_count_o", CBITS'(nz_count_o), CBITS'(exp_nz));
        for (int k = 0; k < NUM_EL; k++) begin
            check_equal($sformatf("coef_o[%0d]", k), CBITS'(coef_o[k*CW +: CW]),
                        CBITS'(exp_coef[k*CW +: CW]));
        end
    endtask

    // --------------------
    // One four-phase request
    // --------------------
    task automatic run_request(input xform_cmd_pkg::op_e op, input logic [`XF_SHIFT_W-1:0] shv,
                               input logic [PIX_BITS-1:0] src_px,
                               input logic [PIX_BITS-1:0] ref_px);
        logic [CBITS-1:0]    exp_coef;
        logic [`XF_NZ_W-1:0] exp_nz;
        logic                exp_err;
        logic [31:0]         r;
        int                  lat;
        exp_err = (op == xform_cmd_pkg::OP_RSV2) || (op == xform_cmd_pkg::OP_RSV3);
        expected_result(src_px, ref_px, op, shv, exp_coef, exp_nz);
        @(posedge clk);
        req_i   <= 1'b1;
        op_i    <= op;
        shift_i <= shv;
        src_i   <= src_px;
        ref_i   <= ref_px;
        lat = 0;
        do begin
            @(negedge clk);
            lat++;
            if (lat > 16) begin
                abort_run("ack_o did not rise within 16 cycles of a request");
            end
        end while (ack_o !== 1'b1);
        // E0 is one edge after the drive and ack shows at the negedge after E1 or E3
        check_equal("ack_o latency", CBITS'(lat), CBITS'(exp_err ? 3 : 5));
        check_outputs(exp_coef, exp_nz, exp_err);
        got_coef = coef_o;
        r = rand_next();
        repeat (r % 6) begin                 // Host holds req_i and outputs must not move
            @(negedge clk);
            check_outputs(exp_coef, exp_nz, exp_err);
        end
        @(posedge clk);
        req_i <= 1'b0;
        @(negedge clk);
        check_outputs(exp_coef, exp_nz, exp_err);
        repeat (3) begin                     // Falls once with no second ack
            @(negedge clk);
            check_equal("ack_o", CBITS'(ack_o), '0);
        end
    endtask

    // --------------------
    // Test sequence
    // --------------------
    initial begin
        rst_n   = 1'b0;
        req_i   = 1'b0;
        op_i    = xform_cmd_pkg::OP_FDCT;
        shift_i = '0;
        src_i   = '0;
        ref_i   = '0;
        repeat (8) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        check_equal("ack_o", CBITS'(ack_o), '0);
        check_equal("err_o", CBITS'(err_o), '0);
        check_equal("nz_count_o", CBITS'(nz_count_o), '0);
        check_equal("coef_o", coef_o, '0);

        for (int i = 0; i < 150; i++) begin
            make_block(pick_kind(i));
            rnd = rand_next();
            run_request(xform_cmd_pkg::OP_FDCT, rnd[2:0], blk_src, blk_ref);
        end

        for (int i = 0; i < 100; i++) begin
            make_block(pick_kind(i));
            rnd = rand_next();
            sh  = (i == 0) ? '0 : rnd[2:0];
            run_request(xform_cmd_pkg::OP_FDCT_Q, sh, blk_src, blk_ref);
            if (sh == '0) begin
                raw_coef = got_coef;
                run_request(xform_cmd_pkg::OP_FDCT, sh, blk_src, blk_ref);
                check_equal("coef_o shift 0 against raw", raw_coef, got_coef);
            end
        end

        // Reserved opcodes each followed by a valid block
        make_block(0);
        run_request(xform_cmd_pkg::OP_RSV2, 3'd2, blk_src, blk_ref);
        make_block(0);
        run_request(xform_cmd_pkg::OP_FDCT, 3'd0, blk_src, blk_ref);
        make_block(4);
        run_request(xform_cmd_pkg::OP_RSV3, 3'd5, blk_src, blk_ref);
        make_block(0);
        run_request(xform_cmd_pkg::OP_FDCT_Q, 3'd3, blk_src, blk_ref);

        $display("All checks passed");
        $finish;
    end

endmodule

// File: all.f
+incdir+hdl
hdl/xform_cmd_pkg.sv
hdl/xform_coef_pkg.sv
hdl/xform_cmd_decode.sv
hdl/fdct4x4.sv
hdl/coef_quant.sv
hdl/xform_top.sv
test/tb_xform_top.sv

// File: Makefile
VERILATOR ?= verilator
FLAGS     ?= --assert --timing
TOP       ?= tb_xform_top
FILELIST  ?= all.f
PASS_MSG  := All checks passed

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

# Pass or fail comes from the run output, not the exit code
sim:
	$(VERILATOR) --binary $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	@out="$$(./obj_dir/V$(TOP) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -qF "$(PASS_MSG)"

clean:
	rm -rf obj_dir
